/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gf_mult
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* clmul_school.sv */
`default_nettype none

`include "gf_consts.svh"

module clmul_school (
    input  wire  [`GF_WIDTH/2-1:0] i_x,
    input  wire  [`GF_WIDTH/2-1:0] i_y,
    output logic [`GF_WIDTH-2:0]   o_z
);

    logic [`GF_WIDTH-2:0] acc;

    // One shifted copy of x per set bit of y, summed without carries.
    always_comb begin
        acc = '0;
        for (int i = 0; i < `GF_WIDTH/2; i++) begin
            if (i_y[i]) begin
                acc = acc ^ ({{(`GF_WIDTH/2-1){1'b0}}, i_x} << i);
            end
        end
    end

    assign o_z = acc;

endmodule

`default_nettype wire

/* gf_consts.svh */
`ifndef GF_CONSTS_SVH
`define GF_CONSTS_SVH

// Field width of GF(2^128).
`define GF_WIDTH 128

// Carry-less product of two field elements, degree up to 254.
`define GF_PROD_WIDTH 255

// Entries in the product buffer.
`define GF_FIFO_DEPTH 4

// Low terms x^7 + x^2 + x + 1 of the reduction polynomial.
`define GF_POLY_TAIL 8'h87

`endif

/* gf_mult_koa_pipe.sv */
`default_nettype none

`include "gf_consts.svh"

module gf_mult_koa_pipe (
    input  wire                     i_clock,
    input  wire                     i_reset,
    input  wire                     i_op_valid,
    output logic                    o_op_ready,
    input  wire gf_pkg::gf_operands_t i_op,
    output logic                    o_prod_valid,
    input  wire                     i_prod_ready,
    output gf_pkg::gf_prod_t        o_prod
);

    logic [`GF_WIDTH-1:0]   a_nat;
    logic [`GF_WIDTH-1:0]   b_nat;
    logic [`GF_WIDTH/2-1:0] a_mix;
    logic [`GF_WIDTH/2-1:0] b_mix;
    logic [`GF_WIDTH-2:0]   d_lo;
    logic [`GF_WIDTH-2:0]   d_hi;
    logic [`GF_WIDTH-2:0]   d_mix;
    logic [`GF_WIDTH-2:0]   d_mid;

    logic [`GF_WIDTH-2:0]   d_lo_q;
    logic [`GF_WIDTH-2:0]   d_hi_q;
    logic [`GF_WIDTH-2:0]   d_mid_q;
    logic                   valid_q;
    logic                   load;

    // Back to natural order, bit i is the x^i coefficient.
    assign a_nat = {<<{i_op.a}};
    assign b_nat = {<<{i_op.b}};

    assign a_mix = a_nat[`GF_WIDTH-1:`GF_WIDTH/2] ^ a_nat[`GF_WIDTH/2-1:0];
    assign b_mix = b_nat[`GF_WIDTH-1:`GF_WIDTH/2] ^ b_nat[`GF_WIDTH/2-1:0];

    clmul_school u_mul_lo (
        .i_x (a_nat[`GF_WIDTH/2-1:0]),
        .i_y (b_nat[`GF_WIDTH/2-1:0]),
        .o_z (d_lo)
    );

    clmul_school u_mul_hi (
        .i_x (a_nat[`GF_WIDTH-1:`GF_WIDTH/2]),
        .i_y (b_nat[`GF_WIDTH-1:`GF_WIDTH/2]),
        .o_z (d_hi)
    );

    clmul_school u_mul_mix (
        .i_x (a_mix),
        .i_y (b_mix),
        .o_z (d_mix)
    );

    // Karatsuba middle term.
    assign d_mid = d_mix ^ d_hi ^ d_lo;

    // Stage takes a pair when empty or when its product is leaving.
    assign o_op_ready = !valid_q || i_prod_ready;
    assign load       = i_op_valid && o_op_ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (i_prod_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            d_lo_q  <= d_lo;
            d_hi_q  <= d_hi;
            d_mid_q <= d_mid;
        end
    end

    // Align the three terms at x^128, x^64 and x^0.
    always_comb begin
        o_prod.raw = {d_hi_q, {`GF_WIDTH{1'b0}}}
                   ^ {{(`GF_WIDTH/2){1'b0}}, d_mid_q, {(`GF_WIDTH/2){1'b0}}}
                   ^ {{`GF_WIDTH{1'b0}}, d_lo_q};
    end

    assign o_prod_valid = valid_q;

    // A stalled product must not change or vanish.
    a_prod_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        o_prod_valid && !i_prod_ready |=> o_prod_valid && $stable(o_prod));

endmodule

`default_nettype wire

/* gf_mult_top.sv */
`default_nettype none

module gf_mult_top (
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire                      i_op_valid,
    output logic                     o_op_ready,
    input  wire gf_pkg::gf_operands_t i_op,
    output logic                     o_res_valid,
    input  wire                      i_res_ready,
    output gf_pkg::gf_elem_t         o_res
);

    // Multiplier to buffer.
    wire                   mult_valid;
    wire                   mult_ready;
    wire gf_pkg::gf_prod_t mult_prod;

    // Buffer to reduction.
    wire                   fifo_valid;
    wire                   fifo_ready;
    wire gf_pkg::gf_prod_t fifo_prod;

    gf_mult_koa_pipe u_mult (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_op_valid   (i_op_valid),
        .o_op_ready   (o_op_ready),
        .i_op         (i_op),
        .o_prod_valid (mult_valid),
        .i_prod_ready (mult_ready),
        .o_prod       (mult_prod)
    );

    product_fifo u_fifo (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_wr_valid (mult_valid),
        .o_wr_ready (mult_ready),
        .i_wr_data  (mult_prod),
        .o_rd_valid (fifo_valid),
        .i_rd_ready (fifo_ready),
        .o_rd_data  (fifo_prod)
    );

    gf_reduce u_reduce (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_prod_valid (fifo_valid),
        .o_prod_ready (fifo_ready),
        .i_prod       (fifo_prod),
        .o_res_valid  (o_res_valid),
        .i_res_ready  (i_res_ready),
        .o_res        (o_res)
    );

endmodule

`default_nettype wire

/* gf_pkg.sv */
`default_nettype none

`include "gf_consts.svh"

package gf_pkg;

    // Field element, GCM reflected order (bit 0 is the x^127 coefficient).
    typedef logic [`GF_WIDTH-1:0] gf_elem_t;

    // Operand pair on the input port.
    typedef struct packed {
        gf_elem_t a;
        gf_elem_t b;
    } gf_operands_t;

    // Natural-order product split at x^128.
    typedef struct packed {
        logic [`GF_PROD_WIDTH-`GF_WIDTH-1:0] hi;
        logic [`GF_WIDTH-1:0]                lo;
    } gf_prod_parts_t;

    // Unreduced product, seen whole or as high and low halves.
    typedef union packed {
        logic [`GF_PROD_WIDTH-1:0] raw;
        gf_prod_parts_t            parts;
    } gf_prod_t;

endpackage

`default_nettype wire

/* gf_reduce.sv */
`default_nettype none

`include "gf_consts.svh"

module gf_reduce (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_prod_valid,
    output logic                 o_prod_ready,
    input  wire gf_pkg::gf_prod_t i_prod,
    output logic                 o_res_valid,
    input  wire                  i_res_ready,
    output gf_pkg::gf_elem_t     o_res
);

    localparam logic [7:0] POLY_TAIL = `GF_POLY_TAIL;

    // First fold reaches x^133, so 7 spare bits above x^127.
    logic [`GF_WIDTH+6:0]  fold1;
    logic [6:0]            ovf;
    logic [14:0]           fold2;
    logic [`GF_WIDTH-1:0]  red_nat;
    gf_pkg::gf_elem_t      res_d;

    gf_pkg::gf_elem_t      res_q;
    logic                  valid_q;
    logic                  load;

    // Replace x^128 by the tail, once for the high half.
    always_comb begin
        fold1 = {7'b0, i_prod.parts.lo};
        for (int k = 0; k < 8; k++) begin
            if (POLY_TAIL[k]) begin
                fold1 = fold1 ^ ({8'b0, i_prod.parts.hi} << k);
            end
        end
    end

    assign ovf = fold1[`GF_WIDTH+6:`GF_WIDTH];

    // Second pass for the small overflow, degree stays below 13.
    always_comb begin
        fold2 = '0;
        for (int k = 0; k < 8; k++) begin
            if (POLY_TAIL[k]) begin
                fold2 = fold2 ^ ({8'b0, ovf} << k);
            end
        end
    end

    assign red_nat = fold1[`GF_WIDTH-1:0] ^ {{(`GF_WIDTH-15){1'b0}}, fold2};

    // Back to GCM bit order.
    assign res_d = {<<{red_nat}};

    assign o_prod_ready = !valid_q || i_res_ready;
    assign load         = i_prod_valid && o_prod_ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (i_res_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            res_q <= res_d;
        end
    end

    assign o_res_valid = valid_q;
    assign o_res       = res_q;

    a_res_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res));

endmodule

`default_nettype wire

/* list.f */
+incdir+.
gf_pkg.sv
clmul_school.sv
gf_mult_koa_pipe.sv
product_fifo.sv
gf_reduce.sv
gf_mult_top.sv
tb_checker.sv
tb_gf_mult.sv

/* product_fifo.sv */
`default_nettype none

`include "gf_consts.svh"

module product_fifo (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_wr_valid,
    output logic                 o_wr_ready,
    input  wire gf_pkg::gf_prod_t i_wr_data,
    output logic                 o_rd_valid,
    input  wire                  i_rd_ready,
    output gf_pkg::gf_prod_t     o_rd_data
);

    localparam int PTR_W = $clog2(`GF_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`GF_FIFO_DEPTH + 1);

    gf_pkg::gf_prod_t mem [`GF_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full = (count == CNT_W'(`GF_FIFO_DEPTH));

    // When full, a write is still fine if the head leaves this cycle.
    assign o_wr_ready = !full || i_rd_ready;
    assign o_rd_valid = (count != '0);

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    // Head entry shown ahead of the read.
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge i_clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`GF_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(`GF_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge i_clock) disable iff (i_reset)
        count <= CNT_W'(`GF_FIFO_DEPTH));

    // An empty buffer has its pointers level.
    a_empty_ptr_match: assert property (@(posedge i_clock) disable iff (i_reset)
        !o_rd_valid |-> wr_ptr == rd_ptr);

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

`include "gf_consts.svh"

module tb_checker (
    input  wire                       i_clock,
    input  wire                       i_reset,
    input  wire                       i_op_valid,
    input  wire                       i_op_ready,
    input  wire gf_pkg::gf_operands_t i_op,
    input  wire                       i_res_valid,
    input  wire                       i_res_ready,
    input  wire gf_pkg::gf_elem_t     i_res,
    output int                        o_accepted,
    output int                        o_results,
    output int                        o_errors,
    output int                        o_pending,
    output gf_pkg::gf_elem_t          o_last_exp,
    output gf_pkg::gf_elem_t          o_last_res
);
    timeunit 1ns;
    timeprecision 1ps;

    gf_pkg::gf_elem_t exp_q [$];

    int               n_accepted = 0;
    int               n_results  = 0;
    int               n_errors   = 0;
    int               n_pending  = 0;
    gf_pkg::gf_elem_t last_exp   = '0;
    gf_pkg::gf_elem_t last_res   = '0;

    // Bit-serial GCM multiply, spec bit i of x is port bit 127-i.
    function automatic gf_pkg::gf_elem_t gf_mul_ref(input gf_pkg::gf_elem_t x,
                                                    input gf_pkg::gf_elem_t y);
        logic [7:0]       tail;
        logic [7:0]       r_byte;
        gf_pkg::gf_elem_t z;
        gf_pkg::gf_elem_t v;
        logic             carry;
        tail = `GF_POLY_TAIL;
        // R = 11100001 || 0^120, the tail bits mirrored.
        for (int k = 0; k < 8; k++) begin
            r_byte[7-k] = tail[k];
        end
        z = '0;
        v = y;
        for (int i = 0; i < `GF_WIDTH; i++) begin
            if (x[`GF_WIDTH-1-i]) begin
                z = z ^ v;
            end
            carry = v[0];
            v = v >> 1;
            if (carry) begin
                v[`GF_WIDTH-1 -: 8] = v[`GF_WIDTH-1 -: 8] ^ r_byte;
            end
        end
        return z;
    endfunction

    always @(posedge i_clock) begin
        gf_pkg::gf_elem_t expected;
        if (i_reset) begin
            // Anything in flight is lost with the reset.
            exp_q.delete();
            n_pending <= 0;
        end else begin
            if (i_op_valid && i_op_ready) begin
                exp_q.push_back(gf_mul_ref(i_op.a, i_op.b));
                n_accepted <= n_accepted + 1;
            end
            if (i_res_valid && i_res_ready) begin
                n_results <= n_results + 1;
                last_res  <= i_res;
                if (exp_q.size() == 0) begin
                    $display("Unexpected result %h arrived with no input waiting for it",
                             i_res);
                    n_errors <= n_errors + 1;
                end else begin
                    expected = exp_q.pop_front();
                    last_exp <= expected;
                    if (i_res !== expected) begin
                        $display("[ERROR] o_res expected %h got %h", expected, i_res);
                        n_errors <= n_errors + 1;
                    end
                end
            end
            n_pending <= exp_q.size();
        end
    end

    assign o_accepted = n_accepted;
    assign o_results  = n_results;
    assign o_errors   = n_errors;
    assign o_pending  = n_pending;
    assign o_last_exp = last_exp;
    assign o_last_res = last_res;

endmodule

`default_nettype wire

/* tb_gf_mult.sv */
`default_nettype none

`include "gf_consts.svh"

module tb_gf_mult;
    timeunit 1ns;
    timeprecision 1ps;

    // Known, identity and zero, two streams, stall, reset batch.
    localparam int TOTAL_OPS   = 1 + 3 + 200 + 200 + (`GF_FIFO_DEPTH + 3) + 12 + 20;
    localparam int CYCLE_LIMIT = TOTAL_OPS * 8 + 200;

    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    localparam gf_pkg::gf_elem_t VEC_H  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam gf_pkg::gf_elem_t VEC_X  = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam gf_pkg::gf_elem_t GF_ONE = {1'b1, {(`GF_WIDTH-1){1'b0}}};

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 op_valid;
    logic                 op_ready;
    gf_pkg::gf_operands_t op;
    logic                 res_valid;
    logic                 res_ready;
    gf_pkg::gf_elem_t     res;

    int                   accepted;
    int                   results;
    int                   check_errors;
    int                   pending;
    gf_pkg::gf_elem_t     last_exp;
    gf_pkg::gf_elem_t     last_res;

    logic [31:0]          rng_state = 32'd67;
    int                   ready_mode = READY_HIGH;
    int                   tb_errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   cycles = 0;
    int                   acc_start;
    int                   res_start;
    int                   err_start;

    always #4 clock = ~clock;

    gf_mult_top u_dut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_op_valid  (op_valid),
        .o_op_ready  (op_ready),
        .i_op        (op),
        .o_res_valid (res_valid),
        .i_res_ready (res_ready),
        .o_res       (res)
    );

    tb_checker u_check (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_op_valid  (op_valid),
        .i_op_ready  (op_ready),
        .i_op        (op),
        .i_res_valid (res_valid),
        .i_res_ready (res_ready),
        .i_res       (res),
        .o_accepted  (accepted),
        .o_results   (results),
        .o_errors    (check_errors),
        .o_pending   (pending),
        .o_last_exp  (last_exp),
        .o_last_res  (last_res)
    );

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_word(output logic [31:0] w);
        rng_state = xorshift32(rng_state);
        w = rng_state;
    endtask

    task automatic random_elem(output gf_pkg::gf_elem_t e);
        logic [31:0] w;
        for (int i = 0; i < `GF_WIDTH / 32; i++) begin
            random_word(w);
            e[i*32 +: 32] = w;
        end
    endtask

    // One falling edge with the output ready pattern updated.
    task automatic tick();
        logic [31:0] r;
        @(negedge clock);
        case (ready_mode)
            READY_HIGH: res_ready = 1'b1;
            READY_RANDOM: begin
                random_word(r);
                res_ready = r[7];
            end
            default: res_ready = 1'b0;
        endcase
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic send_pair(input gf_pkg::gf_elem_t a, input gf_pkg::gf_elem_t b);
        int n;
        n = accepted;
        op.a = a;
        op.b = b;
        op_valid = 1'b1;
        while (accepted == n) begin
            tick();
        end
        op_valid = 1'b0;
    endtask

    task automatic send_random(input int count, input int max_gap);
        gf_pkg::gf_elem_t a;
        gf_pkg::gf_elem_t b;
        logic [31:0]      r;
        for (int i = 0; i < count; i++) begin
            random_elem(a);
            random_elem(b);
            random_word(r);
            if (max_gap > 0) begin
                idle(int'(r[1:0]) % (max_gap + 1));
            end
            send_pair(a, b);
        end
    endtask

    task automatic drain();
        while (pending != 0) begin
            tick();
        end
        idle(4);
    endtask

    task automatic expect_res(input gf_pkg::gf_elem_t want);
        drain();
        if (last_res !== want) begin
            $display("[ERROR] o_res expected %h got %h", want, last_res);
            tb_errors++;
        end
    endtask

    task automatic snapshot_counts();
        acc_start = accepted;
        res_start = results;
    endtask

    task automatic start_test();
        err_start = check_errors + tb_errors;
        snapshot_counts();
    endtask

    task automatic end_test(input string name);
        int errs;
        drain();
        if (accepted - acc_start != results - res_start) begin
            $display("Test %s accepted %0d inputs but returned %0d results", name,
                     accepted - acc_start, results - res_start);
            tb_errors++;
        end
        errs = check_errors + tb_errors - err_start;
        tests_run++;
        if (errs == 0) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", name, errs);
        end
    endtask

    initial begin
        gf_pkg::gf_elem_t a;
        int               last;
        int               low_run;
        int               stalled;
        reset     = 1'b1;
        op_valid  = 1'b0;
        op        = '0;
        res_ready = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test();
        send_pair(VEC_H, VEC_X);
        end_test("known_vector");
        $display("GCM test-case product H*X = %h", last_exp);

        start_test();
        send_pair(GF_ONE, VEC_X);
        expect_res(VEC_X);
        send_pair(VEC_H, GF_ONE);
        expect_res(VEC_H);
        random_elem(a);
        send_pair(a, '0);
        expect_res('0);
        end_test("identity_zero");

        start_test();
        send_random(200, 0);
        end_test("full_rate_stream");

        start_test();
        ready_mode = READY_RANDOM;
        send_random(200, 3);
        ready_mode = READY_HIGH;
        end_test("back_pressure");

        // Fill every stage until the input port closes.
        start_test();
        ready_mode = READY_LOW;
        tick();
        last = accepted;
        random_elem(op.a);
        random_elem(op.b);
        op_valid = 1'b1;
        low_run = 0;
        while (low_run < 4) begin
            tick();
            if (accepted != last) begin
                last = accepted;
                random_elem(op.a);
                random_elem(op.b);
            end
            if (op_ready) begin
                low_run = 0;
            end else begin
                low_run++;
            end
        end
        stalled = accepted - acc_start;
        if (stalled == 0 || stalled > `GF_FIFO_DEPTH + 2) begin
            $display("Stall accepted %0d pairs, expected 1 to %0d", stalled,
                     `GF_FIFO_DEPTH + 2);
            tb_errors++;
        end
        ready_mode = READY_HIGH;
        while (accepted == last) begin
            tick();
        end
        op_valid = 1'b0;
        end_test("stall_drain");

        start_test();
        send_random(12, 0);
        reset = 1'b1;
        idle(2);
        reset = 1'b0;
        if (res_valid !== 1'b0) begin
            $display("o_res_valid is still high after reset");
            tb_errors++;
        end
        if (op_ready !== 1'b1) begin
            $display("o_op_ready is not high after reset");
            tb_errors++;
        end
        snapshot_counts();
        send_random(20, 0);
        end_test("reset_recovery");

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 check_errors + tb_errors);
        if (tests_failed == 0 && check_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
